// File: source/l2_pkg.sv
package l2_pkg;

	// cache geometry
	// --------------------------------------------------
	localparam int WORD_W      = 32;                  // data word
	localparam int WADDR_W     = 16;                  // word address
	localparam int OFFSET_W    = 2;                   // word within block
	localparam int BLOCK_WORDS = 1 << OFFSET_W;       // 4 words per block
	localparam int LINES       = 4;                   // fully associative
	localparam int LINE_W      = $clog2(LINES);
	localparam int TAG_W       = WADDR_W - OFFSET_W;  // block tag

	// widths with a meaning
	// --------------------------------------------------
	typedef logic [WORD_W-1:0]          word_t;
	typedef logic [WADDR_W-1:0]         waddr_t;
	typedef logic [TAG_W-1:0]           tag_t;
	typedef logic [LINE_W-1:0]          line_t;
	typedef logic [OFFSET_W-1:0]        offset_t;
	typedef logic [LINE_W+OFFSET_W-1:0] ram_addr_t;  // {line, offset}

	// controller FSM
	typedef enum logic [2:0] {
		ST_NORMAL,       // idle, hit/miss decision
		ST_WAIT_READY,   // wait for memory command slot
		ST_PICK_VICTIM,  // latch round-robin line
		ST_EVICT,        // dirty victim to evict buffer
		ST_FILL,         // fill words or L1 words into victim line
		ST_L1_READ,      // block to L1
		ST_L1_WRITE,     // block from L1
		ST_TAG_WAIT      // CAM write settles
	} ctrl_state_t;

endpackage

// File: source/l2_tag_cam.sv
`timescale 1ns/1ns

module l2_tag_cam (
	input  logic          clock_i,
	input  logic          resetn_i,
	input  logic          wren_i,
	input  l2_pkg::line_t line_i,
	input  l2_pkg::tag_t  tag_i,
	output logic          hit_o,
	output l2_pkg::line_t hit_line_o,
	output l2_pkg::tag_t  line_tag_o
);

	logic [l2_pkg::LINES-1:0] valid;                 // one per line
	l2_pkg::tag_t             tags [l2_pkg::LINES];

	// valid bits, cleared on reset
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid <= '0;
		end else if (wren_i) begin
			valid[line_i] <= 1'b1;
		end
	end

	// tag storage
	always_ff @(posedge clock_i) begin
		if (wren_i) begin
			tags[line_i] <= tag_i;
		end
	end

	// parallel compare over all valid lines
	always_comb begin
		hit_o      = 1'b0;
		hit_line_o = '0;
		for (int i = 0; i < l2_pkg::LINES; i++) begin
			if (valid[i] && (tags[i] == tag_i)) begin
				hit_o      = 1'b1;
				hit_line_o = l2_pkg::line_t'(i);
			end
		end
	end

	assign line_tag_o = tags[line_i];  // victim tag for writeback address

endmodule

// File: source/l2_data_ram.sv
`timescale 1ns/1ns

module l2_data_ram (
	input  logic              clock_i,
	input  logic              we_i,
	input  l2_pkg::ram_addr_t addr_i,
	input  l2_pkg::word_t     wdata_i,
	output l2_pkg::word_t     rdata_o
);

	// LINES x BLOCK_WORDS words
	l2_pkg::word_t mem [l2_pkg::LINES * l2_pkg::BLOCK_WORDS];

	always_ff @(posedge clock_i) begin
		if (we_i) begin
			mem[addr_i] <= wdata_i;
		end
	end

	// address comes registered from the controller
	assign rdata_o = mem[addr_i];

endmodule

// File: source/l2_victim_fifo.sv
`timescale 1ns/1ns

module l2_victim_fifo (
	input  logic          clock_i,
	input  logic          resetn_i,
	input  logic          miss_i,
	output l2_pkg::line_t victim_line_o
);

	l2_pkg::line_t ptr;  // next line to replace

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			ptr <= '0;                                       // first miss takes line 0
		end else if (miss_i) begin
			if (ptr == l2_pkg::line_t'(l2_pkg::LINES - 1)) begin
				ptr <= '0;                                   // wrap
			end else begin
				ptr <= ptr + 1'b1;
			end
		end
	end

	assign victim_line_o = ptr;

endmodule

// File: source/l2_ctrl.sv
`timescale 1ns/1ns

module l2_ctrl (
	input  logic              clock_i,
	input  logic              resetn_i,
	// L1 side
	input  logic              l1_req_i,
	input  logic              l1_rw_i,           // 1 is writeback
	input  l2_pkg::tag_t      l1_tag_i,
	input  l2_pkg::word_t     l1_data_i,
	input  logic              l1_ready_read_i,
	input  logic              l1_ready_write_i,
	output logic              l1_read_ack_o,
	output logic              l1_done_o,
	output logic              l1_hit_o,
	output logic              l1_valid_o,
	// tag CAM
	input  logic              cam_hit_i,
	input  l2_pkg::line_t     cam_hit_line_i,
	input  l2_pkg::tag_t      cam_line_tag_i,
	output logic              cam_wren_o,
	output l2_pkg::line_t     cam_line_o,
	// data array
	input  l2_pkg::word_t     ram_rdata_i,
	output logic              ram_we_o,
	output l2_pkg::ram_addr_t ram_addr_o,
	output l2_pkg::word_t     ram_wdata_o,
	// victim pointer
	input  l2_pkg::line_t     victim_line_i,
	output logic              miss_o,
	// fill and evict buffers
	input  logic              fill_ready_i,
	input  l2_pkg::word_t     fill_data_i,
	output logic              fill_ack_o,
	input  logic              evict_ready_i,
	output l2_pkg::word_t     evict_data_o,
	output logic              evict_ack_o,
	// memory commands
	input  logic              mem_ready_i,
	output logic              mem_req_o,
	output logic              mem_rw_o,
	output l2_pkg::waddr_t    mem_addr_o
);

	// state and bookkeeping
	// --------------------------------------------------
	l2_pkg::ctrl_state_t      state;
	logic                     req_pending;   // miss in service, serve as hit after
	logic                     rw_r;          // registered request type
	l2_pkg::offset_t          cnt;           // word in block
	l2_pkg::line_t            line_r;        // hit line or victim line
	logic [l2_pkg::LINES-1:0] dirty;
	logic                     wb_pending;    // write command still owed
	l2_pkg::waddr_t           wb_addr;
	logic                     active;
	logic                     rw_now;
	logic                     last_word;
	logic                     word_rdy;
	l2_pkg::word_t            word_in;

	assign active    = l1_req_i | req_pending;
	assign rw_now    = req_pending ? rw_r : l1_rw_i;
	assign last_word = (cnt == l2_pkg::offset_t'(l2_pkg::BLOCK_WORDS - 1));

	// fill source is memory on read miss, L1 on write miss
	assign word_rdy = rw_r ? l1_ready_read_i : fill_ready_i;
	assign word_in  = rw_r ? l1_data_i : fill_data_i;

	// combinational outputs
	// --------------------------------------------------
	assign l1_hit_o     = active ? cam_hit_i : 1'b1;  // no stall when idle
	assign cam_line_o   = line_r;
	assign cam_wren_o   = (state == l2_pkg::ST_FILL) & word_rdy & last_word;  // tag with last word
	assign evict_data_o = ram_rdata_i;                // word at registered address
	assign evict_ack_o  = (state == l2_pkg::ST_EVICT) & evict_ready_i;
	assign fill_ack_o   = (state == l2_pkg::ST_FILL) & !rw_r & fill_ready_i;
	assign l1_read_ack_o = l1_ready_read_i &
		((state == l2_pkg::ST_L1_WRITE) | ((state == l2_pkg::ST_FILL) & rw_r));

	// FSM
	// --------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state       <= l2_pkg::ST_NORMAL;
			req_pending <= 1'b0;
			rw_r        <= 1'b0;
			cnt         <= '0;
			line_r      <= '0;
			dirty       <= '0;
			wb_pending  <= 1'b0;
			l1_done_o   <= 1'b1;                          // idle means done
			l1_valid_o  <= 1'b0;
			ram_we_o    <= 1'b0;
			miss_o      <= 1'b0;
			mem_req_o   <= 1'b0;
			mem_rw_o    <= 1'b0;
		end else begin
			// pulses default low
			l1_valid_o <= 1'b0;
			ram_we_o   <= 1'b0;
			miss_o     <= 1'b0;
			mem_req_o  <= 1'b0;

			case (state)
				l2_pkg::ST_NORMAL: begin
					if (active) begin
						l1_done_o <= 1'b0;                    // stall L1 on hit or miss
						cnt       <= '0;
						if (cam_hit_i) begin
							line_r      <= cam_hit_line_i;
							req_pending <= 1'b0;
							rw_r        <= rw_now;
							if (rw_now) begin
								dirty[cam_hit_line_i] <= 1'b1;  // block now differs from memory
								state <= l2_pkg::ST_L1_WRITE;
							end else begin
								state <= l2_pkg::ST_L1_READ;
							end
						end else begin
							req_pending <= 1'b1;
							rw_r        <= l1_rw_i;
							state       <= l2_pkg::ST_WAIT_READY;
						end
					end
				end

				l2_pkg::ST_WAIT_READY: begin
					// owed writeback goes out before any new read
					if (mem_ready_i && !wb_pending) begin
						if (!rw_r) begin
							mem_req_o  <= 1'b1;
							mem_rw_o   <= 1'b0;
							mem_addr_o <= {l1_tag_i, {l2_pkg::OFFSET_W{1'b0}}};
						end
						state <= l2_pkg::ST_PICK_VICTIM;
					end
				end

				l2_pkg::ST_PICK_VICTIM: begin
					line_r     <= victim_line_i;
					miss_o     <= 1'b1;                       // advance pointer
					ram_addr_o <= {victim_line_i, cnt};       // first evict word
					if (dirty[victim_line_i]) begin
						state <= l2_pkg::ST_EVICT;
					end else begin
						state <= l2_pkg::ST_FILL;
					end
				end

				l2_pkg::ST_EVICT: begin
					if (evict_ready_i) begin
						if (cnt == '0) begin
							wb_pending <= 1'b1;
							wb_addr    <= {cam_line_tag_i, {l2_pkg::OFFSET_W{1'b0}}};
						end
						ram_addr_o <= {line_r, cnt + 1'b1};  // next word ready next cycle
						cnt        <= cnt + 1'b1;            // wraps to 0 for fill
						if (last_word) begin
							dirty[line_r] <= 1'b0;
							state         <= l2_pkg::ST_FILL;
						end
					end
				end

				l2_pkg::ST_FILL: begin
					if (word_rdy) begin
						ram_we_o    <= 1'b1;
						ram_addr_o  <= {line_r, cnt};
						ram_wdata_o <= word_in;
						cnt         <= cnt + 1'b1;
						if (last_word) begin
							state <= l2_pkg::ST_TAG_WAIT;
							if (rw_r) begin
								// write miss is complete, no hit to serve
								dirty[line_r] <= 1'b1;
								req_pending   <= 1'b0;
								l1_done_o     <= 1'b1;
							end
						end
					end
				end

				l2_pkg::ST_TAG_WAIT: begin
					state <= l2_pkg::ST_NORMAL;
				end

				l2_pkg::ST_L1_READ: begin
					if (l1_ready_write_i) begin
						ram_addr_o <= {line_r, cnt};
						l1_valid_o <= 1'b1;                   // data follows address
						cnt        <= cnt + 1'b1;
						if (last_word) begin
							l1_done_o <= 1'b1;
							state     <= l2_pkg::ST_NORMAL;
						end
					end
				end

				l2_pkg::ST_L1_WRITE: begin
					if (l1_ready_read_i) begin
						ram_we_o    <= 1'b1;
						ram_addr_o  <= {line_r, cnt};
						ram_wdata_o <= l1_data_i;
						cnt         <= cnt + 1'b1;
						if (last_word) begin
							l1_done_o <= 1'b1;
							state     <= l2_pkg::ST_NORMAL;
						end
					end
				end

				default: begin
					state <= l2_pkg::ST_NORMAL;
				end
			endcase

			// writeback command, independent of FSM
			// --------------------------------------------------
			if (wb_pending && mem_ready_i) begin
				mem_req_o  <= 1'b1;
				mem_rw_o   <= 1'b1;
				mem_addr_o <= wb_addr;
				wb_pending <= 1'b0;                          // one command per eviction
			end
		end
	end

endmodule

// File: source/l2_cache_top.sv
`timescale 1ns/1ns

module l2_cache_top (
	input  logic           clock_i,
	input  logic           resetn_i,
	// L1 side
	input  logic           l1_req_i,
	input  logic           l1_rw_i,
	input  l2_pkg::tag_t   l1_tag_i,
	input  l2_pkg::word_t  l1_data_i,
	input  logic           l1_ready_read_i,
	input  logic           l1_ready_write_i,
	output logic           l1_read_ack_o,
	output logic           l1_done_o,
	output logic           l1_hit_o,
	output logic           l1_valid_o,
	output l2_pkg::word_t  l1_data_o,
	// fill and evict buffers
	input  logic           fill_ready_i,
	input  l2_pkg::word_t  fill_data_i,
	output logic           fill_ack_o,
	input  logic           evict_ready_i,
	output l2_pkg::word_t  evict_data_o,
	output logic           evict_ack_o,
	// memory commands
	input  logic           mem_ready_i,
	output logic           mem_req_o,
	output logic           mem_rw_o,
	output l2_pkg::waddr_t mem_addr_o
);

	// internal wiring
	// --------------------------------------------------
	logic              cam_wren;
	l2_pkg::line_t     cam_line;
	logic              cam_hit;
	l2_pkg::line_t     hit_line;
	l2_pkg::tag_t      line_tag;
	logic              ram_we;
	l2_pkg::ram_addr_t ram_addr;
	l2_pkg::word_t     ram_wdata;
	l2_pkg::word_t     ram_rdata;
	logic              miss;
	l2_pkg::line_t     victim_line;

	assign l1_data_o = ram_rdata;  // valid with l1_valid_o

	l2_ctrl u_ctrl (
		.clock_i          (clock_i),
		.resetn_i         (resetn_i),
		.l1_req_i         (l1_req_i),
		.l1_rw_i          (l1_rw_i),
		.l1_tag_i         (l1_tag_i),
		.l1_data_i        (l1_data_i),
		.l1_ready_read_i  (l1_ready_read_i),
		.l1_ready_write_i (l1_ready_write_i),
		.l1_read_ack_o    (l1_read_ack_o),
		.l1_done_o        (l1_done_o),
		.l1_hit_o         (l1_hit_o),
		.l1_valid_o       (l1_valid_o),
		.cam_hit_i        (cam_hit),
		.cam_hit_line_i   (hit_line),
		.cam_line_tag_i   (line_tag),
		.cam_wren_o       (cam_wren),
		.cam_line_o       (cam_line),
		.ram_rdata_i      (ram_rdata),
		.ram_we_o         (ram_we),
		.ram_addr_o       (ram_addr),
		.ram_wdata_o      (ram_wdata),
		.victim_line_i    (victim_line),
		.miss_o           (miss),
		.fill_ready_i     (fill_ready_i),
		.fill_data_i      (fill_data_i),
		.fill_ack_o       (fill_ack_o),
		.evict_ready_i    (evict_ready_i),
		.evict_data_o     (evict_data_o),
		.evict_ack_o      (evict_ack_o),
		.mem_ready_i      (mem_ready_i),
		.mem_req_o        (mem_req_o),
		.mem_rw_o         (mem_rw_o),
		.mem_addr_o       (mem_addr_o)
	);

	// request tag goes straight to the compare
	l2_tag_cam u_tag_cam (
		.clock_i    (clock_i),
		.resetn_i   (resetn_i),
		.wren_i     (cam_wren),
		.line_i     (cam_line),
		.tag_i      (l1_tag_i),
		.hit_o      (cam_hit),
		.hit_line_o (hit_line),
		.line_tag_o (line_tag)
	);

	l2_data_ram u_data_ram (
		.clock_i (clock_i),
		.we_i    (ram_we),
		.addr_i  (ram_addr),
		.wdata_i (ram_wdata),
		.rdata_o (ram_rdata)
	);

	l2_victim_fifo u_victim_fifo (
		.clock_i       (clock_i),
		.resetn_i      (resetn_i),
		.miss_i        (miss),
		.victim_line_o (victim_line)
	);

endmodule

// File: sim/tb_l2_cache.sv
`timescale 1ns/1ns

module tb_l2_cache;

	// DUT ports
	// --------------------------------------------------
	logic                  clock_i;
	logic                  resetn_i;
	logic                  l1_req_i;
	logic                  l1_rw_i;
	l2_pkg::tag_t          l1_tag_i;
	l2_pkg::word_t         l1_data_i;
	logic                  l1_ready_read_i;
	logic                  l1_ready_write_i;
	logic                  l1_read_ack_o;
	logic                  l1_done_o;
	logic                  l1_hit_o;
	logic                  l1_valid_o;
	l2_pkg::word_t         l1_data_o;
	logic                  fill_ready_i;
	l2_pkg::word_t         fill_data_i;
	logic                  fill_ack_o;
	logic                  evict_ready_i;
	l2_pkg::word_t         evict_data_o;
	logic                  evict_ack_o;
	logic                  mem_ready_i;
	logic                  mem_req_o;
	logic                  mem_rw_o;
	l2_pkg::waddr_t        mem_addr_o;

	// request list from the data file
	bit                    req_w   [64];
	l2_pkg::tag_t          req_tag [64];
	l2_pkg::word_t         req_wd  [64][4];
	int                    nreq;

	// memory, buffers and reference model
	// --------------------------------------------------
	l2_pkg::word_t         mem_model [l2_pkg::waddr_t];  // only written blocks
	l2_pkg::word_t         fill_q[$];                    // fill buffer contents
	l2_pkg::waddr_t        exp_wb_q[$];                  // write commands still owed
	l2_pkg::waddr_t        rdcmd_q[$];
	l2_pkg::word_t         evict_got[$];
	l2_pkg::word_t         rd_got[$];
	int                    ack_cnt;
	l2_pkg::word_t         cur_wdata [4];                // block the L1 writes back
	logic                  last_hit;
	bit                    ref_valid [l2_pkg::LINES];
	bit                    ref_dirty [l2_pkg::LINES];
	l2_pkg::tag_t          ref_tag   [l2_pkg::LINES];
	l2_pkg::word_t         ref_data  [l2_pkg::LINES][l2_pkg::BLOCK_WORDS];
	int                    ref_ptr;                      // round-robin victim

	integer                seed = 34;
	int                    cycles;
	int                    cycle_limit;
	int                    errors;
	int                    tests_passed;
	int                    tests_failed;

	l2_cache_top dut (.*);

	initial begin
		clock_i = 1'b0;
		forever #4 clock_i = ~clock_i;  // 8 ns period
	end

	// run limit, 200 cycles per request
	initial begin
		while (cycles <= cycle_limit) begin
			@(posedge clock_i);
			cycles++;
		end
		$display("timeout, run stopped after %0d cycles", cycles);
		$display("Verification failed");
		$finish;
	end

	function automatic l2_pkg::waddr_t block_addr(input l2_pkg::tag_t t);
		return {t, 2'b00};  // tag then zero offset
	endfunction

	// unwritten memory follows the address pattern
	function automatic l2_pkg::word_t mem_word(input l2_pkg::waddr_t a);
		if (mem_model.exists(a)) begin
			return mem_model[a];
		end
		return {16'h0000, a} ^ 32'hA5A50000;
	endfunction

	task automatic expect_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_idle_outputs();
		int errs_before;
		errs_before = errors;
		expect_bit("l1_done_o", l1_done_o, 1'b1);
		expect_bit("mem_req_o", mem_req_o, 1'b0);
		expect_bit("fill_ack_o", fill_ack_o, 1'b0);
		expect_bit("evict_ack_o", evict_ack_o, 1'b0);
		expect_bit("l1_read_ack_o", l1_read_ack_o, 1'b0);
		expect_bit("l1_valid_o", l1_valid_o, 1'b0);
		if (errors == errs_before) begin
			tests_passed++;
			$display("reset state ok");
		end else begin
			tests_failed++;
			$display("reset state FAILED");
		end
	endtask

	// monitors, sampled mid-cycle
	// --------------------------------------------------
	task automatic sample_outputs();
		l2_pkg::word_t dummy;
		l2_pkg::waddr_t dummy_a;
		last_hit = l1_hit_o;
		if (mem_req_o) begin
			if (mem_rw_o) begin
				if (exp_wb_q.size() == 0) begin
					$display("unexpected memory write command to %h", mem_addr_o);
					errors++;
				end else begin
					if (mem_addr_o !== exp_wb_q[0]) begin
						$display("[ERROR] mem_addr_o got %h expected %h", mem_addr_o, exp_wb_q[0]);
						errors++;
					end
					dummy_a = exp_wb_q.pop_front();
				end
			end else begin
				rdcmd_q.push_back(mem_addr_o);
				for (int k = 0; k < 4; k++) begin
					fill_q.push_back(mem_word(mem_addr_o + l2_pkg::waddr_t'(k)));
				end
			end
		end
		if (fill_ack_o) begin
			if (fill_q.size() == 0) begin
				$display("fill buffer popped while empty");
				errors++;
			end else begin
				dummy = fill_q.pop_front();
			end
		end
		if (evict_ack_o) evict_got.push_back(evict_data_o);
		if (l1_valid_o) rd_got.push_back(l1_data_o);
		if (l1_read_ack_o) ack_cnt++;
	endtask

	task automatic drive_inputs();
		mem_ready_i      = (($random(seed) & 3) != 0);  // high about 3 in 4
		evict_ready_i    = (($random(seed) & 3) != 0);
		l1_ready_write_i = (($random(seed) & 3) != 0);
		l1_ready_read_i  = (($random(seed) & 3) != 0);
		if (fill_q.size() > 0) begin
			fill_ready_i = (($random(seed) & 3) != 0);
			fill_data_i  = fill_q[0];
		end else begin
			fill_ready_i = 1'b0;
			fill_data_i  = '0;
		end
		l1_data_i = cur_wdata[(ack_cnt < 4) ? ack_cnt : 3];
	endtask

	task automatic next_cycle();
		@(negedge clock_i);
		sample_outputs();
		@(posedge clock_i);
		#1;
		drive_inputs();
	endtask

	// one request, predicted by the reference model
	// --------------------------------------------------
	task automatic run_request(input int n);
		bit             is_w;
		l2_pkg::tag_t   t;
		bit             hit;
		int             line;
		int             victim;
		bit             exp_ev;
		l2_pkg::word_t  exp_ev_data [4];
		l2_pkg::word_t  exp_rd [4];
		int             errs_before;
		bit             first;
		bit             seen_low;
		bit             finished;
		logic           hit_got;
		is_w        = req_w[n];
		t           = req_tag[n];
		hit         = 1'b0;
		line        = 0;
		exp_ev      = 1'b0;
		errs_before = errors;
		for (int i = 0; i < l2_pkg::LINES; i++) begin
			if (ref_valid[i] && ref_tag[i] == t) begin
				hit  = 1'b1;
				line = i;
			end
		end
		if (!hit) begin
			victim  = ref_ptr;
			ref_ptr = (ref_ptr + 1) % l2_pkg::LINES;
			if (ref_valid[victim] && ref_dirty[victim]) begin
				exp_ev = 1'b1;
				for (int k = 0; k < 4; k++) begin
					exp_ev_data[k] = ref_data[victim][k];
					mem_model[block_addr(ref_tag[victim]) + l2_pkg::waddr_t'(k)] =
						ref_data[victim][k];
				end
				exp_wb_q.push_back(block_addr(ref_tag[victim]));
			end
			line             = victim;
			ref_valid[line]  = 1'b1;
			ref_tag[line]    = t;
			ref_dirty[line]  = 1'b0;
			if (!is_w) begin
				for (int k = 0; k < 4; k++) begin
					ref_data[line][k] = mem_word(block_addr(t) + l2_pkg::waddr_t'(k));
				end
			end
		end
		for (int k = 0; k < 4; k++) begin
			if (is_w) ref_data[line][k] = req_wd[n][k];
			exp_rd[k]    = ref_data[line][k];
			cur_wdata[k] = req_wd[n][k];
		end
		if (is_w) ref_dirty[line] = 1'b1;

		rdcmd_q.delete();
		evict_got.delete();
		rd_got.delete();
		ack_cnt   = 0;
		l1_req_i  = 1'b1;
		l1_rw_i   = is_w;
		l1_tag_i  = t;
		l1_data_i = cur_wdata[0];
		first     = 1'b1;
		seen_low  = 1'b0;
		finished  = 1'b0;
		hit_got   = 1'b0;
		while (!finished) begin
			next_cycle();
			if (first) begin
				hit_got = last_hit;  // tag compare in the first cycle
				first   = 1'b0;
			end
			if (!l1_done_o) seen_low = 1'b1;
			else if (seen_low) finished = 1'b1;
		end
		l1_req_i = 1'b0;
		l1_tag_i = ~t;  // L1 lets go of the tag once done is high
		next_cycle();   // last read word lands here

		if (hit_got !== hit) begin
			$display("[ERROR] l1_hit_o got %h expected %h", hit_got, hit);
			errors++;
		end
		if (rdcmd_q.size() != ((!hit && !is_w) ? 1 : 0)) begin
			$display("wrong number of memory read commands, saw %0d", rdcmd_q.size());
			errors++;
		end else if (rdcmd_q.size() == 1 && rdcmd_q[0] !== block_addr(t)) begin
			$display("[ERROR] mem_addr_o got %h expected %h", rdcmd_q[0], block_addr(t));
			errors++;
		end
		if (evict_got.size() != (exp_ev ? 4 : 0)) begin
			$display("wrong number of evict words, saw %0d", evict_got.size());
			errors++;
		end else if (exp_ev) begin
			for (int k = 0; k < 4; k++) begin
				if (evict_got[k] !== exp_ev_data[k]) begin
					$display("[ERROR] evict_data_o got %h expected %h",
						evict_got[k], exp_ev_data[k]);
					errors++;
				end
			end
		end
		if (rd_got.size() != (is_w ? 0 : 4)) begin
			$display("wrong number of words returned to the L1, saw %0d", rd_got.size());
			errors++;
		end else if (!is_w) begin
			for (int k = 0; k < 4; k++) begin
				if (rd_got[k] !== exp_rd[k]) begin
					$display("[ERROR] l1_data_o got %h expected %h", rd_got[k], exp_rd[k]);
					errors++;
				end
			end
		end
		if (ack_cnt != (is_w ? 4 : 0)) begin
			$display("wrong number of L1 write acks, saw %0d", ack_cnt);
			errors++;
		end
		if (fill_q.size() != 0) begin
			$display("fill words left unread in the fill buffer");
			errors++;
		end
		if (errors == errs_before) tests_passed++;
		else tests_failed++;
		$display("request %0d %s tag %h %s %s", n, is_w ? "W" : "R", t,
			hit ? "hit " : "miss", (errors == errs_before) ? "ok" : "FAILED");
	endtask

	task automatic load_requests();
		integer          fd;
		integer          r;
		reg [63:0]       op;
		reg [31:0]       tv;
		reg [31:0]       w [4];
		reg [8*160-1:0]  rest;
		nreq = 0;
		fd   = $fopen("sim/l2_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open sim/l2_input.txt");
			errors++;
		end else begin
			while (!$feof(fd) && nreq < 64) begin
				r = $fscanf(fd, "%s", op);
				if (r == 1) begin
					if (op[7:0] == "#") begin
						r = $fgets(rest, fd);  // comment line
					end else if (op[7:0] == "W") begin
						r = $fscanf(fd, "%h %h %h %h %h", tv, w[0], w[1], w[2], w[3]);
						req_w[nreq]   = 1'b1;
						req_tag[nreq] = tv[13:0];
						for (int k = 0; k < 4; k++) req_wd[nreq][k] = w[k];
						nreq++;
					end else begin
						r = $fscanf(fd, "%h", tv);
						req_w[nreq]   = 1'b0;
						req_tag[nreq] = tv[13:0];
						for (int k = 0; k < 4; k++) req_wd[nreq][k] = '0;
						nreq++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// main sequence
	// --------------------------------------------------
	initial begin
		resetn_i         = 1'b0;
		l1_req_i         = 1'b0;
		l1_rw_i          = 1'b0;
		l1_tag_i         = '0;
		l1_data_i        = '0;
		l1_ready_read_i  = 1'b0;
		l1_ready_write_i = 1'b0;
		fill_ready_i     = 1'b0;
		fill_data_i      = '0;
		evict_ready_i    = 1'b0;
		mem_ready_i      = 1'b0;
		errors           = 0;
		tests_passed     = 0;
		tests_failed     = 0;
		ref_ptr          = 0;
		for (int i = 0; i < l2_pkg::LINES; i++) begin
			ref_valid[i] = 1'b0;
			ref_dirty[i] = 1'b0;
		end
		for (int k = 0; k < 4; k++) cur_wdata[k] = '0;
		load_requests();
		cycle_limit = 200 * nreq;

		repeat (3) @(posedge clock_i);
		#1;
		resetn_i = 1'b1;

		// idle outputs after reset
		@(negedge clock_i);
		check_idle_outputs();
		@(posedge clock_i);
		#1;
		drive_inputs();

		for (int n = 0; n < nreq; n++) begin
			run_request(n);
		end
		while (exp_wb_q.size() > 0) next_cycle();  // late write commands
		repeat (4) next_cycle();

		$display("tests passed %0d failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: sim/l2_input.txt
# op tag [w0 w1 w2 w3], op R reads a block, W writes one back from the L1
# tag is 14 bit hex, words are 32 bit hex
R 0010
R 0010
W 0020 20000000 20000001 20000002 20000003
R 0020
W 0010 10001111 10002222 10003333 10004444
R 0030
R 0040
# cache full, round robin from line 0
R 0050
R 0060
R 0010
R 0020
W 0070 70000aaa 70000bbb 70000ccc 70000ddd
W 0050 5000cafe 5000beef 5000f00d 5000d00d
R 0070
W 0070 77770001 77770002 77770003 77770004
R 0080
R 0090
R 00a0
R 0070
R 0050

// File: project.f
source/l2_pkg.sv
source/l2_tag_cam.sv
source/l2_data_ram.sv
source/l2_victim_fifo.sv
source/l2_ctrl.sv
source/l2_cache_top.sv
sim/tb_l2_cache.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --top-module tb_l2_cache -f project.f -Mdir obj_dir -o tb_l2_cache

run: compile
	./obj_dir/tb_l2_cache | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
